/* ntt_bf2x2.f */
src/ntt_defines_pkg.sv
src/bf_lane_if.sv
src/ntt_mod_mul.sv
src/ntt_mod_addsub.sv
src/ntt_butterfly.sv
src/ntt_butterfly2x2.sv
src/ntt_bf2x2_top.sv
tb/tb_ntt_bf2x2.sv

/* tb/tb_ntt_bf2x2.sv */
//======================================================================
// Random testbench for the 2x2 butterfly network with a modular
// reference model, ready timing checks and a zeroize check
//======================================================================

`timescale 1ns/100ps
`default_nettype none

module tb_ntt_bf2x2;

    // The ML-DSA prime, used by the reference model with 64-bit integers
    localparam longint Q = 8380417;

    logic        clk;
    logic        reset_n;
    logic        zeroize_i;
    logic [2:0]  mode_i;
    logic        enable_i;
    logic [22:0] opd_w [0:7];
    logic [22:0] res_w [0:3];
    logic        ready_o;

    logic [31:0] lfsr;
    int          cyc;
    string       test_name;
    int          value_errors;
    int          ready_errors;
    int          other_errors;

    // Expected result sets and the cycle on which each becomes visible
    logic [91:0] exp_q [$];
    int          due_q [$];

    ntt_bf2x2_top u_dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .mode_i    (mode_i),
        .enable_i  (enable_i),
        .opd0_i    (opd_w[0]),
        .opd1_i    (opd_w[1]),
        .opd2_i    (opd_w[2]),
        .opd3_i    (opd_w[3]),
        .opd4_i    (opd_w[4]),
        .opd5_i    (opd_w[5]),
        .opd6_i    (opd_w[6]),
        .opd7_i    (opd_w[7]),
        .res0_o    (res_w[0]),
        .res1_o    (res_w[1]),
        .res2_o    (res_w[2]),
        .res3_o    (res_w[3]),
        .ready_o   (ready_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //==================================================================
    // Random source and reference model
    //==================================================================

    // Galois LFSR for x^32 + x^22 + x^2 + x + 1, one step per bit taken
    function automatic logic lfsr_bit();
        logic out;
        out  = lfsr[0];
        lfsr = {1'b0, lfsr[31:1]} ^ (out ? 32'h8020_0003 : 32'h0);
        return out;
    endfunction

    // 23 random bits, folded once so the coefficient is below q
    function automatic logic [22:0] rand_coef();
        logic [22:0] v;
        int          i;
        v = '0;
        for (i = 0; i < 23; i++) begin
            v = {v[21:0], lfsr_bit()};
        end
        if (v >= 23'(Q)) begin
            v = v - 23'(Q);
        end
        return v;
    endfunction

    function automatic int latency_of(input logic [2:0] m);
        if (m == ntt_defines_pkg::MODE_CT || m == ntt_defines_pkg::MODE_GS) begin
            return ntt_defines_pkg::NET_LATENCY;
        end else if (m == ntt_defines_pkg::MODE_PWM) begin
            return ntt_defines_pkg::PWM_LATENCY;
        end
        return ntt_defines_pkg::PWA_LATENCY;
    endfunction

    // Ct gives u + wv and u - wv, gs gives u + v and (u - v)w
    task automatic butterfly_model(input longint u, input longint v, input longint w,
                                   input bit gs, output longint ru, output longint rv);
        longint t;
        if (gs) begin
            ru = (u + v) % Q;
            rv = (((u - v + Q) % Q) * w) % Q;
        end else begin
            t  = (w * v) % Q;
            ru = (u + t) % Q;
            rv = (u - t + Q) % Q;
        end
    endtask

    // Expected words for the operands now on the bus, res0 in the top word
    task automatic model_set(input logic [2:0] m, output logic [91:0] exp);
        longint o [0:7];
        longint r [0:3];
        longint s0u;
        longint s0v;
        longint s1u;
        longint s1v;
        bit     gs;
        int     i;
        for (i = 0; i < 8; i++) begin
            o[i] = longint'(opd_w[i]);
        end
        gs = (m == ntt_defines_pkg::MODE_GS);
        if (m == ntt_defines_pkg::MODE_CT || gs) begin
            // First stage, then the crossover into units 10 and 11
            butterfly_model(o[0], o[1], o[2], gs, s0u, s0v);
            butterfly_model(o[3], o[4], o[5], gs, s1u, s1v);
            butterfly_model(s0u, s1u, o[6], gs, r[0], r[1]);
            butterfly_model(s0v, s1v, o[7], gs, r[2], r[3]);
        end else begin
            for (i = 0; i < 4; i++) begin
                if (m == ntt_defines_pkg::MODE_PWM) begin
                    r[i] = (o[2*i] * o[2*i+1]) % Q;
                end else if (m == ntt_defines_pkg::MODE_PWA) begin
                    r[i] = (o[2*i] + o[2*i+1]) % Q;
                end else begin
                    r[i] = (o[2*i] - o[2*i+1] + Q) % Q;
                end
            end
        end
        exp = {23'(r[0]), 23'(r[1]), 23'(r[2]), 23'(r[3])};
    endtask

    //==================================================================
    // Cycle stepping, driving and checking
    //==================================================================

    // Outputs only move on the rising edge, so the falling edge is safe
    task automatic check_outputs();
        logic [91:0] exp;
        int          i;
        if (due_q.size() > 0 && due_q[0] <= cyc) begin
            exp = exp_q.pop_front();
            void'(due_q.pop_front());
            assert (ready_o === 1'b1) else begin
                ready_errors++;
                $display("%s: ready_o is low at cycle %0d while a result is due",
                         test_name, cyc);
            end
            for (i = 0; i < 4; i++) begin
                assert (res_w[i] === exp[(3-i)*23 +: 23]) else begin
                    value_errors++;
                    $display("MISMATCH %s res%0d expected %0d actual %0d",
                             test_name, i, exp[(3-i)*23 +: 23], res_w[i]);
                end
            end
        end else begin
            assert (ready_o === 1'b0) else begin
                ready_errors++;
                $display("%s: ready_o is high at cycle %0d with no result due",
                         test_name, cyc);
            end
        end
    endtask

    task automatic check_cleared();
        int i;
        for (i = 0; i < 4; i++) begin
            assert (res_w[i] === 23'd0) else begin
                value_errors++;
                $display("MISMATCH %s res%0d expected 0 actual %0d", test_name, i, res_w[i]);
            end
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        cyc++;
        check_outputs();
    endtask

    // New operands on every cycle, the expected set only when enabled
    task automatic drive_set(input logic en);
        logic [91:0] exp;
        int          i;
        for (i = 0; i < 8; i++) begin
            opd_w[i] = rand_coef();
        end
        enable_i = en;
        if (en) begin
            model_set(mode_i, exp);
            exp_q.push_back(exp);
            due_q.push_back(cyc + latency_of(mode_i));
        end
    endtask

    task automatic drain_pipeline();
        int waited;
        waited   = 0;
        enable_i = 1'b0;
        // The last result goes out and ready_o has to fall behind it
        while ((due_q.size() > 0 || ready_o !== 1'b0)
               && waited < ntt_defines_pkg::NET_LATENCY + 4) begin
            next_cycle();
            waited++;
        end
        assert (due_q.size() == 0 && ready_o === 1'b0) else begin
            other_errors++;
            $display("%s: timed out with %0d results waiting or ready_o still high",
                     test_name, due_q.size());
            exp_q.delete();
            due_q.delete();
        end
        // A short idle tail where ready_o has to stay low
        next_cycle();
        next_cycle();
    endtask

    // Gapped streams pick enable from the LFSR on every cycle
    task automatic run_stream(input logic [2:0] m, input string name,
                              input int count, input bit gaps);
        int n;
        test_name = name;
        next_cycle();
        mode_i = m;
        for (n = 0; n < count; n++) begin
            drive_set(gaps ? lfsr_bit() : 1'b1);
            next_cycle();
        end
        drain_pipeline();
    endtask

    //==================================================================
    // Test sequence
    //==================================================================

    initial begin
        int i;
        lfsr         = 32'hc0e1_179f;
        cyc          = 0;
        value_errors = 0;
        ready_errors = 0;
        other_errors = 0;
        reset_n      = 1'b0;
        zeroize_i    = 1'b0;
        mode_i       = ntt_defines_pkg::MODE_CT;
        enable_i     = 1'b0;
        for (i = 0; i < 8; i++) begin
            opd_w[i] = '0;
        end

        // Results read zero and ready_o stays low through and after reset
        test_name = "reset";
        for (i = 0; i < 8; i++) begin
            next_cycle();
            check_cleared();
        end
        reset_n = 1'b1;
        for (i = 0; i < 4; i++) begin
            next_cycle();
            check_cleared();
        end

        run_stream(ntt_defines_pkg::MODE_CT, "ct stream", 40, 1'b0);
        run_stream(ntt_defines_pkg::MODE_GS, "gs stream", 40, 1'b0);
        run_stream(ntt_defines_pkg::MODE_PWM, "pwm", 30, 1'b0);
        run_stream(ntt_defines_pkg::MODE_PWA, "pwa", 30, 1'b0);
        run_stream(ntt_defines_pkg::MODE_PWS, "pws", 30, 1'b0);

        // Broken enable patterns exercise every rise and fall of ready_o
        run_stream(ntt_defines_pkg::MODE_CT, "ready ct", 24, 1'b1);
        run_stream(ntt_defines_pkg::MODE_GS, "ready gs", 24, 1'b1);
        run_stream(ntt_defines_pkg::MODE_PWM, "ready pwm", 24, 1'b1);
        run_stream(ntt_defines_pkg::MODE_PWA, "ready pwa", 24, 1'b1);
        run_stream(ntt_defines_pkg::MODE_PWS, "ready pws", 24, 1'b1);

        // Zeroize lands in the middle of a ct stream with sets in flight
        test_name = "zeroize";
        next_cycle();
        mode_i = ntt_defines_pkg::MODE_CT;
        for (i = 0; i < 12; i++) begin
            drive_set(1'b1);
            next_cycle();
        end
        enable_i  = 1'b0;
        zeroize_i = 1'b1;
        exp_q.delete();
        due_q.delete();
        next_cycle();
        check_cleared();
        zeroize_i = 1'b0;
        run_stream(ntt_defines_pkg::MODE_CT, "ct after zeroize", 20, 1'b0);

        $display("Errors: %0d value, %0d ready timing, %0d other",
                 value_errors, ready_errors, other_errors);
        if (value_errors + ready_errors + other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/ntt_bf2x2_top.sv */
//======================================================================
// Top level of the 2x2 butterfly network with plain operand and
// result ports
//======================================================================

`timescale 1ns/100ps
`default_nettype none

module ntt_bf2x2_top (
    input  wire                                clk,
    input  wire                                reset_n,
    input  wire                                zeroize_i,
    input  wire  [ntt_defines_pkg::MODE_W-1:0] mode_i,
    input  wire                                enable_i,
    // Operand words, transform set or pointwise pairs depending on mode
    input  wire  [ntt_defines_pkg::COEF_W-1:0] opd0_i,
    input  wire  [ntt_defines_pkg::COEF_W-1:0] opd1_i,
    input  wire  [ntt_defines_pkg::COEF_W-1:0] opd2_i,
    input  wire  [ntt_defines_pkg::COEF_W-1:0] opd3_i,
    input  wire  [ntt_defines_pkg::COEF_W-1:0] opd4_i,
    input  wire  [ntt_defines_pkg::COEF_W-1:0] opd5_i,
    input  wire  [ntt_defines_pkg::COEF_W-1:0] opd6_i,
    input  wire  [ntt_defines_pkg::COEF_W-1:0] opd7_i,
    // u20, v20, u21, v21 for transforms, r0 to r3 for pointwise modes
    output logic [ntt_defines_pkg::COEF_W-1:0] res0_o,
    output logic [ntt_defines_pkg::COEF_W-1:0] res1_o,
    output logic [ntt_defines_pkg::COEF_W-1:0] res2_o,
    output logic [ntt_defines_pkg::COEF_W-1:0] res3_o,
    output logic                               ready_o
);

    ntt_defines_pkg::bf_operands_u opd;
    ntt_defines_pkg::bf_results_u  res;

    // Port 0 lands in the top word of each union
    assign opd = {opd0_i, opd1_i, opd2_i, opd3_i, opd4_i, opd5_i, opd6_i, opd7_i};
    assign {res0_o, res1_o, res2_o, res3_o} = res;

    ntt_butterfly2x2 u_bf2x2 (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .mode_i    (mode_i),
        .enable_i  (enable_i),
        .opd_i     (opd),
        .res_o     (res),
        .ready_o   (ready_o)
    );

endmodule

`default_nettype wire

/* src/ntt_butterfly2x2.sv */
//======================================================================
// Two-stage network of four butterflies with crossover, twiddle delay,
// pointwise lane mapping and the ready tracker
//======================================================================

`timescale 1ns/100ps
`default_nettype none

module ntt_butterfly2x2 (
    input  wire                                 clk,
    input  wire                                 reset_n,
    input  wire                                 zeroize_i,
    input  wire  [ntt_defines_pkg::MODE_W-1:0]  mode_i,
    input  wire                                 enable_i,
    input  wire  ntt_defines_pkg::bf_operands_u opd_i,
    output ntt_defines_pkg::bf_results_u        res_o,
    output logic                                ready_o
);

    localparam int W       = ntt_defines_pkg::COEF_W;
    localparam int WD      = ntt_defines_pkg::BF_LATENCY;
    localparam int RD      = ntt_defines_pkg::NET_LATENCY;
    localparam int DEPTH_W = $clog2(RD + 1);

    logic                pw_mode;
    logic [WD-1:0][W-1:0] w10_r;
    logic [WD-1:0][W-1:0] w11_r;

    logic [DEPTH_W-1:0] ready_depth;
    logic [RD-1:0]      ready_r;
    logic [RD:0]        ready_pad;
    logic [RD-1:0]      ready_nxt;

    // Lane 0 is unit 00, 1 is unit 01, 2 is unit 10 and 3 is unit 11
    bf_lane_if lane [0:3] ();

    assign pw_mode = mode_i inside {ntt_defines_pkg::MODE_PWM,
                                    ntt_defines_pkg::MODE_PWA,
                                    ntt_defines_pkg::MODE_PWS};

    //==================================================================
    // Operand feed and crossover
    //==================================================================

    // First stage. The pair a0, b0 sits on the same bits as u00, v00
    assign lane[0].u = opd_i.tf.u00;
    assign lane[0].v = opd_i.tf.v00;
    assign lane[0].w = opd_i.tf.w00;
    assign lane[1].u = pw_mode ? opd_i.pw.a1 : opd_i.tf.u01;
    assign lane[1].v = pw_mode ? opd_i.pw.b1 : opd_i.tf.v01;
    assign lane[1].w = opd_i.tf.w01;

    // Second stage, the u outputs meet in unit 10 and the v outputs in 11
    assign lane[2].u = pw_mode ? opd_i.pw.a2 : lane[0].res_u;
    assign lane[2].v = pw_mode ? opd_i.pw.b2 : lane[1].res_u;
    assign lane[2].w = w10_r[WD-1];
    assign lane[3].u = pw_mode ? opd_i.pw.a3 : lane[0].res_v;
    assign lane[3].v = pw_mode ? opd_i.pw.b3 : lane[1].res_v;
    assign lane[3].w = w11_r[WD-1];

    // Second-stage twiddles wait for the first-stage butterflies
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            w10_r <= '0;
            w11_r <= '0;
        end else if (zeroize_i) begin
            w10_r <= '0;
            w11_r <= '0;
        end else begin
            w10_r <= {w10_r[WD-2:0], opd_i.tf.w10};
            w11_r <= {w11_r[WD-2:0], opd_i.tf.w11};
        end
    end

    for (genvar n = 0; n < 4; n++) begin : g_bf
        ntt_butterfly u_bf (
            .clk       (clk),
            .reset_n   (reset_n),
            .zeroize_i (zeroize_i),
            .mode_i    (mode_i),
            .lane      (lane[n])
        );
    end

    // Transform results come from the second stage only
    always_comb begin
        if (pw_mode) begin
            res_o.pw.r0 = lane[0].res_u;
            res_o.pw.r1 = lane[1].res_u;
            res_o.pw.r2 = lane[2].res_u;
            res_o.pw.r3 = lane[3].res_u;
        end else begin
            res_o.tf.u20 = lane[2].res_u;
            res_o.tf.v20 = lane[2].res_v;
            res_o.tf.u21 = lane[3].res_u;
            res_o.tf.v21 = lane[3].res_v;
        end
    end

    //==================================================================
    // Ready tracker
    //==================================================================

    // Enable enters the shift chain at a depth equal to the mode latency
    always_comb begin
        case (mode_i)
            ntt_defines_pkg::MODE_CT,
            ntt_defines_pkg::MODE_GS:
                ready_depth = DEPTH_W'(ntt_defines_pkg::NET_LATENCY);
            ntt_defines_pkg::MODE_PWM:
                ready_depth = DEPTH_W'(ntt_defines_pkg::PWM_LATENCY);
            ntt_defines_pkg::MODE_PWA,
            ntt_defines_pkg::MODE_PWS:
                ready_depth = DEPTH_W'(ntt_defines_pkg::PWA_LATENCY);
            default:
                ready_depth = '0;
        endcase
    end

    assign ready_pad = {1'b0, ready_r};

    // Bits below the entry point shift toward bit 0, bits above stay clear
    always_comb begin
        for (int i = 0; i < RD; i++) begin
            if (i + 1 == ready_depth) begin
                ready_nxt[i] = enable_i;
            end else if (i + 1 < ready_depth) begin
                ready_nxt[i] = ready_pad[i+1];
            end else begin
                ready_nxt[i] = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ready_r <= '0;
        end else if (zeroize_i) begin
            ready_r <= '0;
        end else begin
            ready_r <= ready_nxt;
        end
    end

    assign ready_o = ready_r[0];

endmodule

`default_nettype wire

/* src/ntt_butterfly.sv */
//======================================================================
// One butterfly unit: ct and gs butterflies, pointwise multiply, add
// and subtract, with delay lines that balance the two paths
//======================================================================

`timescale 1ns/100ps
`default_nettype none

module ntt_butterfly (
    input  wire                                clk,
    input  wire                                reset_n,
    input  wire                                zeroize_i,
    input  wire  [ntt_defines_pkg::MODE_W-1:0] mode_i,
    bf_lane_if.core                            lane
);

    localparam int W = ntt_defines_pkg::COEF_W;
    localparam int D = ntt_defines_pkg::MUL_LATENCY;

    logic is_ct;
    logic is_pwm;
    logic is_pws;

    // Arithmetic unit operands and results
    logic [W-1:0] mul_a;
    logic [W-1:0] mul_b;
    logic [W-1:0] mul_p;
    logic [W-1:0] add_a;
    logic [W-1:0] add_b;
    logic [W-1:0] add_s;
    logic [W-1:0] sub_a;
    logic [W-1:0] sub_b;
    logic [W-1:0] sub_s;

    // Shared delay line, u in ct mode and u + v in gs mode
    logic [D-1:0][W-1:0] dly_r;
    logic [W-1:0]        dly_in;
    // Twiddle held back by the add/sub stage in gs mode
    logic [W-1:0]        w_gs_r;

    assign is_ct  = (mode_i == ntt_defines_pkg::MODE_CT);
    assign is_pwm = (mode_i == ntt_defines_pkg::MODE_PWM);
    assign is_pws = (mode_i == ntt_defines_pkg::MODE_PWS);

    //==================================================================
    // Operand routing
    //==================================================================

    always_comb begin
        // Gs order by default, add and subtract first, then multiply
        add_a  = lane.u;
        add_b  = lane.v;
        sub_a  = lane.u;
        sub_b  = lane.v;
        mul_a  = sub_s;
        mul_b  = w_gs_r;
        dly_in = add_s;
        if (is_ct) begin
            // Ct multiplies first and meets the delayed u afterwards
            mul_a  = lane.v;
            mul_b  = lane.w;
            add_a  = dly_r[D-1];
            add_b  = mul_p;
            sub_a  = dly_r[D-1];
            sub_b  = mul_p;
            dly_in = lane.u;
        end else if (is_pwm) begin
            mul_a = lane.u;
            mul_b = lane.v;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            dly_r  <= '0;
            w_gs_r <= '0;
        end else if (zeroize_i) begin
            dly_r  <= '0;
            w_gs_r <= '0;
        end else begin
            dly_r  <= {dly_r[D-2:0], dly_in};
            w_gs_r <= lane.w;
        end
    end

    //==================================================================
    // Arithmetic units
    //==================================================================

    ntt_mod_mul u_mul (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .a_i       (mul_a),
        .b_i       (mul_b),
        .p_o       (mul_p)
    );

    // Adds in ct, gs and pwa, subtracts in pws
    ntt_mod_addsub u_add (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .sub_i     (is_pws),
        .a_i       (add_a),
        .b_i       (add_b),
        .s_o       (add_s)
    );

    ntt_mod_addsub u_sub (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .sub_i     (1'b1),
        .a_i       (sub_a),
        .b_i       (sub_b),
        .s_o       (sub_s)
    );

    // Every result comes straight from a register, the mode only selects
    always_comb begin
        lane.res_u = '0;
        lane.res_v = '0;
        case (mode_i)
            ntt_defines_pkg::MODE_CT: begin
                lane.res_u = add_s;
                lane.res_v = sub_s;
            end
            ntt_defines_pkg::MODE_GS: begin
                lane.res_u = dly_r[D-1];
                lane.res_v = mul_p;
            end
            ntt_defines_pkg::MODE_PWM: lane.res_u = mul_p;
            ntt_defines_pkg::MODE_PWA,
            ntt_defines_pkg::MODE_PWS: lane.res_u = add_s;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* src/ntt_mod_addsub.sv */
//======================================================================
// Registered modular add or subtract for operands below q
//======================================================================

`timescale 1ns/100ps
`default_nettype none

module ntt_mod_addsub (
    input  wire                                clk,
    input  wire                                reset_n,
    input  wire                                zeroize_i,
    input  wire                                sub_i,
    input  wire  [ntt_defines_pkg::COEF_W-1:0] a_i,
    input  wire  [ntt_defines_pkg::COEF_W-1:0] b_i,
    output logic [ntt_defines_pkg::COEF_W-1:0] s_o
);

    localparam int W = ntt_defines_pkg::COEF_W;
    localparam logic [W:0] Q_EXT = {1'b0, ntt_defines_pkg::MLDSA_Q};

    // One spare bit holds the carry or the borrow
    logic [W:0] raw;
    logic [W:0] fixed;

    always_comb begin
        if (sub_i) begin
            raw   = {1'b0, a_i} - {1'b0, b_i};
            // A borrow means a < b, and adding q wraps it back into range
            fixed = raw[W] ? raw + Q_EXT : raw;
        end else begin
            raw   = {1'b0, a_i} + {1'b0, b_i};
            fixed = (raw >= Q_EXT) ? raw - Q_EXT : raw;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s_o <= '0;
        end else if (zeroize_i) begin
            s_o <= '0;
        end else begin
            s_o <= fixed[W-1:0];
        end
    end

endmodule

`default_nettype wire

/* src/ntt_mod_mul.sv */
//======================================================================
// Three-stage multiplier modulo q with folding reduction that uses
// 2^23 = 2^13 - 1 (mod q)
//======================================================================

`timescale 1ns/100ps
`default_nettype none

module ntt_mod_mul (
    input  wire                                clk,
    input  wire                                reset_n,
    input  wire                                zeroize_i,
    input  wire  [ntt_defines_pkg::COEF_W-1:0] a_i,
    input  wire  [ntt_defines_pkg::COEF_W-1:0] b_i,
    output logic [ntt_defines_pkg::COEF_W-1:0] p_o
);

    localparam int W      = ntt_defines_pkg::COEF_W;
    // Exponent of the middle term of q
    localparam int K      = 13;
    localparam int FOLD_W = W + 4;
    localparam int RED_W  = W + 2;
    localparam logic [W-1:0] Q = ntt_defines_pkg::MLDSA_Q;

    logic [2*W-1:0]    prod_r;
    logic [W-1:0]      lo;
    logic [W-1:0]      hi;
    logic [FOLD_W-1:0] fold1;
    logic [RED_W-1:0]  fold2;
    logic [RED_W-1:0]  red_r;
    logic [RED_W-1:0]  red_sub;

    assign lo = prod_r[W-1:0];
    assign hi = prod_r[2*W-1:W];

    // First fold. hi*2^23 becomes hi*2^13 - hi, and the part of hi*2^13
    // above bit 23 folds once more. Adding 2q keeps the sum positive
    assign fold1 = FOLD_W'(lo)
                 + FOLD_W'({hi[W-K-1:0], {K{1'b0}}})
                 + FOLD_W'({hi[W-1:W-K], {K{1'b0}}})
                 + FOLD_W'({Q, 1'b0})
                 - FOLD_W'(hi)
                 - FOLD_W'(hi[W-1:W-K]);

    // Second fold of the four top bits, offset by q. Result is below 3q
    assign fold2 = RED_W'(fold1[W-1:0])
                 + RED_W'({fold1[FOLD_W-1:W], {K{1'b0}}})
                 + RED_W'(Q)
                 - RED_W'(fold1[FOLD_W-1:W]);

    // Final correction into the range [0, q)
    always_comb begin
        if (red_r >= RED_W'({Q, 1'b0})) begin
            red_sub = red_r - RED_W'({Q, 1'b0});
        end else if (red_r >= RED_W'(Q)) begin
            red_sub = red_r - RED_W'(Q);
        end else begin
            red_sub = red_r;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_r <= '0;
            red_r  <= '0;
            p_o    <= '0;
        end else if (zeroize_i) begin
            prod_r <= '0;
            red_r  <= '0;
            p_o    <= '0;
        end else begin
            prod_r <= (2*W)'(a_i) * (2*W)'(b_i);
            red_r  <= fold2;
            p_o    <= red_sub[W-1:0];
        end
    end

endmodule

`default_nettype wire

/* src/bf_lane_if.sv */
//======================================================================
// Operand and result lane between the network and one butterfly
//======================================================================

`timescale 1ns/100ps
`default_nettype none

interface bf_lane_if;

    // Operands, driven by the network
    logic [ntt_defines_pkg::COEF_W-1:0] u;
    logic [ntt_defines_pkg::COEF_W-1:0] v;
    logic [ntt_defines_pkg::COEF_W-1:0] w;

    // Registered results, driven by the butterfly
    logic [ntt_defines_pkg::COEF_W-1:0] res_u;
    logic [ntt_defines_pkg::COEF_W-1:0] res_v;

    modport feed (output u, v, w, input res_u, res_v);
    modport core (input u, v, w, output res_u, res_v);

endinterface

`default_nettype wire

/* src/ntt_defines_pkg.sv */
//======================================================================
// Shared constants for the ML-DSA butterfly network: modulus, widths,
// mode codes, pipeline latencies and the operand and result unions
//======================================================================

`default_nettype none

package ntt_defines_pkg;

    // Coefficient width and the ML-DSA prime q = 2^23 - 2^13 + 1
    localparam int COEF_W = 23;
    localparam logic [COEF_W-1:0] MLDSA_Q = 23'd8380417;

    // Operating modes, any code from 5 to 7 leaves the network idle
    localparam int MODE_W = 3;
    localparam logic [MODE_W-1:0] MODE_CT  = 3'd0;
    localparam logic [MODE_W-1:0] MODE_GS  = 3'd1;
    localparam logic [MODE_W-1:0] MODE_PWM = 3'd2;
    localparam logic [MODE_W-1:0] MODE_PWA = 3'd3;
    localparam logic [MODE_W-1:0] MODE_PWS = 3'd4;

    // Pipeline depths in clock cycles
    localparam int MUL_LATENCY    = 3;
    localparam int ADDSUB_LATENCY = 1;
    // A ct or gs butterfly chains one multiply and one add/sub
    localparam int BF_LATENCY     = MUL_LATENCY + ADDSUB_LATENCY;
    // Two butterfly stages back to back
    localparam int NET_LATENCY    = 2 * BF_LATENCY;
    localparam int PWM_LATENCY    = MUL_LATENCY;
    localparam int PWA_LATENCY    = ADDSUB_LATENCY;

    // Eight operand words, read either as a 2x2 transform set or as
    // four independent pointwise pairs. The first word sits at the top
    typedef union packed {
        struct packed {
            logic [COEF_W-1:0] u00;
            logic [COEF_W-1:0] v00;
            logic [COEF_W-1:0] w00;
            logic [COEF_W-1:0] u01;
            logic [COEF_W-1:0] v01;
            logic [COEF_W-1:0] w01;
            logic [COEF_W-1:0] w10;
            logic [COEF_W-1:0] w11;
        } tf;
        struct packed {
            logic [COEF_W-1:0] a0;
            logic [COEF_W-1:0] b0;
            logic [COEF_W-1:0] a1;
            logic [COEF_W-1:0] b1;
            logic [COEF_W-1:0] a2;
            logic [COEF_W-1:0] b2;
            logic [COEF_W-1:0] a3;
            logic [COEF_W-1:0] b3;
        } pw;
    } bf_operands_u;

    // Four result words, transform outputs or pointwise lane results
    typedef union packed {
        struct packed {
            logic [COEF_W-1:0] u20;
            logic [COEF_W-1:0] v20;
            logic [COEF_W-1:0] u21;
            logic [COEF_W-1:0] v21;
        } tf;
        struct packed {
            logic [COEF_W-1:0] r0;
            logic [COEF_W-1:0] r1;
            logic [COEF_W-1:0] r2;
            logic [COEF_W-1:0] r3;
        } pw;
    } bf_results_u;

endpackage

`default_nettype wire
